// ==== hdl/vis_bank_queue.sv ====
`timescale 1ns/1ps

module vis_bank_queue #(
   parameter int NBANK = 2               // banks that may wait for the buffer
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic switch_i,                // correlators finished a bank
   input  logic streamed_i,              // host is done with the buffer
   input  logic fetch_done_i,            // prefetch wrote the last word
   output logic fetch_start_o,           // one cycle pulse that kicks the prefetch
   output logic available_o,             // bank ready for the host
   output logic overflow_o               // sticky flag for a lost switch
);
   import vis_pkg::*;

   localparam int PBITS = $clog2(NBANK + 1);

   bq_state_t        state;
   logic [PBITS-1:0] pending;            // banks announced but not fetched
   logic             issue;              // start a fetch at this edge
   logic             accept;             // this switch gets a slot

   //-------------------------------------------------------------------------
   // decide when to fetch
   //-------------------------------------------------------------------------
   // only from an empty buffer, and not again while the start is still out
   assign issue  = (state == BQ_EMPTY) && (pending != '0) && !fetch_start_o;

   // a full queue still takes the switch when a fetch frees a slot this edge
   assign accept = switch_i && ((pending != PBITS'(NBANK)) || issue);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pending <= '0;
      end else begin
         case ({accept, issue})
            2'b10:   pending <= pending + PBITS'(1);   // new bank in
            2'b01:   pending <= pending - PBITS'(1);   // bank handed to prefetch
            default: pending <= pending;               // none, or both at once
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fetch_start_o <= 1'b0;
      end else begin
         fetch_start_o <= issue;                       // registered single pulse
      end
   end

   //-------------------------------------------------------------------------
   // buffer occupancy
   //-------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= BQ_EMPTY;
      end else begin
         case (state)
            BQ_EMPTY:   if (fetch_start_o) state <= BQ_FILLING;
            BQ_FILLING: if (fetch_done_i)  state <= BQ_FULL;
            BQ_FULL:    if (streamed_i)    state <= BQ_EMPTY;   // host frees it
            default:    state <= BQ_EMPTY;
         endcase
      end
   end

   assign available_o = (state == BQ_FULL);

   // dropped switches are remembered until reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         overflow_o <= 1'b0;
      end else if (switch_i && !accept) begin
         overflow_o <= 1'b1;
      end
   end

   //-------------------------------------------------------------------------
   // checks
   //-------------------------------------------------------------------------
   // a fetch only starts from an empty buffer
   a_start_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      fetch_start_o |-> (state == BQ_EMPTY))
      else $error("vis_bank_queue: fetch start outside BQ_EMPTY");

   // the prefetch only finishes a bank this queue asked for
   a_done_filling: assert property (@(posedge clk_i) disable iff (rst_i)
      fetch_done_i |-> (state == BQ_FILLING))
      else $error("vis_bank_queue: fetch done outside BQ_FILLING");

endmodule

// ==== hdl/vis_pkg.sv ====
package vis_pkg;

   //-------------------------------------------------------------------------
   // word and lane geometry
   //-------------------------------------------------------------------------

   // one visibility word as the correlators hand it out
   localparam int DATA_W    = 24;

   // the host side is byte wide
   localparam int BYTE_W    = 8;

   // byte lanes per word address on the host bus, lane 3 is padding
   localparam int LANES     = 4;

   // low host address bits that pick the lane
   localparam int LANE_BITS = $clog2(LANES);

   //-------------------------------------------------------------------------
   // state encodings
   //-------------------------------------------------------------------------

   // prefetch engine
   //   PF_IDLE  : bus quiet, waiting for a start from the queue
   //   PF_REQ   : strobe out, walking addresses 0..WORDS-1
   //   PF_DONE  : last word being written, done pulse out
   typedef enum logic [1:0] {
      PF_IDLE = 2'd0,
      PF_REQ  = 2'd1,
      PF_DONE = 2'd2
   } pf_state_t;

   // readout buffer occupancy as the bank queue sees it
   //   BQ_EMPTY   : buffer free, a pending bank may be fetched
   //   BQ_FILLING : prefetch running into the buffer
   //   BQ_FULL    : bank complete, host may read it out
   typedef enum logic [1:0] {
      BQ_EMPTY   = 2'd0,
      BQ_FILLING = 2'd1,
      BQ_FULL    = 2'd2
   } bq_state_t;

endpackage

// ==== hdl/vis_prefetch.sv ====
`timescale 1ns/1ps

module vis_prefetch #(
   parameter int WORDS = 576,                        // visibility words per bank
   parameter int ABITS = $clog2(WORDS)               // word address width
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        start_i,      // fetch one bank when the queue asks

   // correlator bus with this block as master
   output logic                        corr_cyc_o,
   output logic                        corr_stb_o,
   output logic [ABITS-1:0]            corr_adr_o,
   input  logic                        corr_ack_i,   // data valid in this cycle
   input  logic [vis_pkg::DATA_W-1:0]  corr_dat_i,

   // word write port into the readout buffer
   output logic                        wr_en_o,
   output logic [ABITS-1:0]            wr_adr_o,
   output logic [vis_pkg::DATA_W-1:0]  wr_dat_o,

   output logic                        done_o,       // one cycle pulse once the bank is in
   output logic [vis_pkg::DATA_W-1:0]  checksum_o    // xor of every word of the bank
);
   import vis_pkg::*;

   pf_state_t        state;
   logic [ABITS-1:0] adr;                            // word being requested
   logic             go;                             // accepted start
   logic             take;                           // acked word this cycle
   logic             last;                           // adr is the final word

   assign go   = start_i && (state == PF_IDLE);
   assign take = corr_stb_o && corr_ack_i;
   assign last = (adr == ABITS'(WORDS - 1));

   //-------------------------------------------------------------------------
   // bus side
   //-------------------------------------------------------------------------
   // cycle stays open while the final word drains into the buffer
   assign corr_cyc_o = (state != PF_IDLE);
   assign corr_stb_o = (state == PF_REQ);          // held through wait states
   assign corr_adr_o = adr;
   assign done_o     = (state == PF_DONE);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= PF_IDLE;
      end else begin
         case (state)
            PF_IDLE: begin
               if (go) begin
                  state <= PF_REQ;                   // strobe shows next cycle
               end
            end
            PF_REQ: begin
               if (take && last) begin
                  state <= PF_DONE;
               end
            end
            PF_DONE: state <= PF_IDLE;               // one cycle for the done pulse
            default: state <= PF_IDLE;
         endcase
      end
   end

   // address walks 0..WORDS-1 and moves only on an ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr <= '0;
      end else if (go) begin
         adr <= '0;
      end else if (take && !last) begin
         adr <= adr + ABITS'(1);
      end
   end

   //-------------------------------------------------------------------------
   // checksum over the bank
   //-------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         checksum_o <= '0;
      end else if (go) begin
         checksum_o <= '0;                           // fresh sum per bank
      end else if (take) begin
         checksum_o <= checksum_o ^ corr_dat_i;
      end
   end

   //-------------------------------------------------------------------------
   // buffer write port
   //-------------------------------------------------------------------------
   // every acked word is registered once and written a cycle later
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_en_o <= 1'b0;
      end else begin
         wr_en_o <= take;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         wr_adr_o <= adr;
         wr_dat_o <= corr_dat_i;                     // only meaningful with wr_en_o
      end
   end

   //-------------------------------------------------------------------------
   // checks
   //-------------------------------------------------------------------------
   a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      corr_stb_o |-> corr_cyc_o)
      else $error("vis_prefetch: strobe without cycle");

   // the queue never starts a bank while one is in flight
   a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      start_i |-> (state == PF_IDLE))
      else $error("vis_prefetch: start while busy");

endmodule

// ==== hdl/vis_readout_buf.sv ====
`timescale 1ns/1ps

module vis_readout_buf #(
   parameter int WORDS = 576,                                   // words per bank
   parameter int ABITS = $clog2(WORDS)
) (
   input  logic                                      clk_i,
   input  logic                                      rst_i,

   // word write port filled by the prefetch engine
   input  logic                                      wr_en_i,
   input  logic [ABITS-1:0]                          wr_adr_i,
   input  logic [vis_pkg::DATA_W-1:0]                wr_dat_i,

   // host bus with this block as slave
   input  logic                                      host_cyc_i,
   input  logic                                      host_stb_i,
   input  logic [ABITS+vis_pkg::LANE_BITS-1:0]       host_adr_i, // word above lane bits
   output logic                                      host_ack_o,
   output logic [vis_pkg::BYTE_W-1:0]                host_byt_o
);
   import vis_pkg::*;

   logic [DATA_W-1:0]       mem [WORDS];               // one bank of words
   logic                    host_req;
   logic [ABITS-1:0]        rd_word;
   logic [LANE_BITS-1:0]    rd_lane;
   logic [DATA_W-1:0]       rd_dat;
   logic [LANES*BYTE_W-1:0] rd_bytes;                  // word padded out to all lanes

   //-------------------------------------------------------------------------
   // write side
   //-------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   //-------------------------------------------------------------------------
   // host read side
   //-------------------------------------------------------------------------
   assign host_req = host_cyc_i && host_stb_i;
   assign rd_word  = host_adr_i[ABITS+LANE_BITS-1:LANE_BITS];
   assign rd_lane  = host_adr_i[LANE_BITS-1:0];

   // words past the bank read as zero
   assign rd_dat   = (32'(rd_word) < WORDS) ? mem[rd_word] : '0;

   // zero extension gives the unused top lane
   assign rd_bytes = (LANES * BYTE_W)'(rd_dat);

   // fixed one cycle latency without wait states
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         host_ack_o <= 1'b0;
      end else begin
         host_ack_o <= host_req;
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_req) begin
         host_byt_o <= rd_bytes[rd_lane*BYTE_W +: BYTE_W];   // lane 0 is bits 7:0
      end
   end

   //-------------------------------------------------------------------------
   // checks
   //-------------------------------------------------------------------------
   // an acked byte comes from a word the prefetch has written
   a_ack_known: assert property (@(posedge clk_i) disable iff (rst_i)
      host_ack_o |-> !$isunknown(host_byt_o))
      else $error("vis_readout_buf: host read an unwritten word");

endmodule

// ==== hdl/vis_top.sv ====
`timescale 1ns/1ps

module vis_top #(
   parameter int   WORDS = 576,                      // visibility words per bank
   parameter int   NBANK = 2,                        // pending bank depth
   localparam int  ABITS = $clog2(WORDS)             // word address width
) (
   input  logic                                   clk_i,
   input  logic                                   rst_i,

   // correlator bus, master
   output logic                                   corr_cyc_o,
   output logic                                   corr_stb_o,
   output logic [ABITS-1:0]                       corr_adr_o,
   input  logic                                   corr_ack_i,
   input  logic [vis_pkg::DATA_W-1:0]             corr_dat_i,

   // host bus (spi side), slave
   input  logic                                   host_cyc_i,
   input  logic                                   host_stb_i,
   input  logic [ABITS+vis_pkg::LANE_BITS-1:0]    host_adr_i,
   output logic                                   host_ack_o,
   output logic [vis_pkg::BYTE_W-1:0]             host_byt_o,

   // status
   input  logic                                   switch_i,     // bank switch pulse
   input  logic                                   streamed_i,   // host finished pulse
   output logic                                   available_o,
   output logic [vis_pkg::DATA_W-1:0]             checksum_o,
   output logic                                   overflow_o
);
   import vis_pkg::*;

   logic              fetch_start;                   // queue -> prefetch
   logic              fetch_done;                    // prefetch -> queue
   logic              wr_en;                         // prefetch -> buffer
   logic [ABITS-1:0]  wr_adr;
   logic [DATA_W-1:0] wr_dat;

   //-------------------------------------------------------------------------
   // bank queue, decides when a bank is fetched
   //-------------------------------------------------------------------------
   vis_bank_queue #(
      .NBANK (NBANK)
   ) vis_bank_queue_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .switch_i      (switch_i),
      .streamed_i    (streamed_i),
      .fetch_done_i  (fetch_done),
      .fetch_start_o (fetch_start),
      .available_o   (available_o),
      .overflow_o    (overflow_o)
   );

   //-------------------------------------------------------------------------
   // prefetch engine, correlators into the buffer
   //-------------------------------------------------------------------------
   vis_prefetch #(
      .WORDS (WORDS),
      .ABITS (ABITS)
   ) vis_prefetch_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .start_i    (fetch_start),
      .corr_cyc_o (corr_cyc_o),
      .corr_stb_o (corr_stb_o),
      .corr_adr_o (corr_adr_o),
      .corr_ack_i (corr_ack_i),
      .corr_dat_i (corr_dat_i),
      .wr_en_o    (wr_en),
      .wr_adr_o   (wr_adr),
      .wr_dat_o   (wr_dat),
      .done_o     (fetch_done),
      .checksum_o (checksum_o)
   );

   //-------------------------------------------------------------------------
   // readout buffer, host reads bytes back
   //-------------------------------------------------------------------------
   vis_readout_buf #(
      .WORDS (WORDS),
      .ABITS (ABITS)
   ) vis_readout_buf_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_en_i    (wr_en),
      .wr_adr_i   (wr_adr),
      .wr_dat_i   (wr_dat),
      .host_cyc_i (host_cyc_i),
      .host_stb_i (host_stb_i),
      .host_adr_i (host_adr_i),
      .host_ack_o (host_ack_o),
      .host_byt_o (host_byt_o)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the visibilities readout testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module vis_tb -Mdir "$OBJ" -o vis_tb_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$OBJ/vis_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
   exit 0
fi
echo "no pass line in $LOG"
exit 1

// ==== verif/vis_corr_model.sv ====
`timescale 1ns/1ps

module vis_corr_model #(
   parameter int ABITS = 6                               // word address width
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        cyc_i,
   input  logic                        stb_i,
   input  logic [ABITS-1:0]            adr_i,
   output logic                        ack_o,            // combinational, data valid with it
   output logic [vis_pkg::DATA_W-1:0]  dat_o
);
   import vis_pkg::*;

   logic [1:0]  waited;                                  // wait cycles spent on this request
   logic [1:0]  target;                                  // wait cycles this request gets
   logic        prev_cyc = 1'b0;                         // cycle level one clock ago
   int unsigned serial   = 0;                            // fetches seen so far

   //------------------------------------------------------------------------
   // slave response
   //------------------------------------------------------------------------
   assign ack_o = stb_i && (waited == target);

   // word content depends on the address and on which fetch this is
   assign dat_o = DATA_W'(32'(adr_i) * 32'h1F3 + serial * 32'h10001);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         waited <= 2'd0;
         target <= 2'($urandom % 4);
      end else if (stb_i) begin
         if (ack_o) begin
            waited <= 2'd0;                              // next request starts fresh
            target <= 2'($urandom % 4);                  // 0 to 3 wait states
         end else begin
            waited <= waited + 2'd1;
         end
      end
   end

   //------------------------------------------------------------------------
   // bank serial
   //------------------------------------------------------------------------
   // a falling cycle ends a fetch, aborted ones included
   always_ff @(posedge clk_i) begin
      prev_cyc <= cyc_i;
      if (!cyc_i && prev_cyc) begin
         serial <= serial + 1;
      end
   end

endmodule

// ==== verif/vis_tb.sv ====
`timescale 1ns/1ps

module vis_tb;
   import vis_pkg::*;

   localparam int          WORDS      = 40;
   localparam int          NBANK      = 2;
   localparam int          ABITS      = $clog2(WORDS);
   localparam int          MAX_CYCLES = 20000;       // about 6 banks plus host reads and margin
   localparam logic [31:0] SEED       = 32'h46c712e9;

   logic                       clk;
   logic                       rst;
   logic                       corr_cyc, corr_stb, corr_ack;
   logic [ABITS-1:0]           corr_adr;
   logic [DATA_W-1:0]          corr_dat;
   logic                       host_cyc, host_stb, host_ack;
   logic [ABITS+LANE_BITS-1:0] host_adr;
   logic [BYTE_W-1:0]          host_byt;
   logic                       bank_switch, host_done;
   logic                       available, overflow;
   logic [DATA_W-1:0]          checksum;

   int          errors      = 0;
   int          checks      = 0;
   int          cycles      = 0;
   int unsigned next_serial = 0;                      // serial of the next fetch the model starts
   int unsigned cur_serial  = 0;                      // serial held in the buffer
   int unsigned want_adr    = 0;                      // next address the fetch should ack

   vis_top #(.WORDS(WORDS), .NBANK(NBANK)) vis_top_i (
      .clk_i(clk), .rst_i(rst),
      .corr_cyc_o(corr_cyc), .corr_stb_o(corr_stb), .corr_adr_o(corr_adr),
      .corr_ack_i(corr_ack), .corr_dat_i(corr_dat),
      .host_cyc_i(host_cyc), .host_stb_i(host_stb), .host_adr_i(host_adr),
      .host_ack_o(host_ack), .host_byt_o(host_byt),
      .switch_i(bank_switch), .streamed_i(host_done),
      .available_o(available), .checksum_o(checksum), .overflow_o(overflow)
   );

   vis_corr_model #(.ABITS(ABITS)) corr_model_i (
      .clk_i(clk), .rst_i(rst), .cyc_i(corr_cyc), .stb_i(corr_stb),
      .adr_i(corr_adr), .ack_o(corr_ack), .dat_o(corr_dat)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                          // 8 ns period
   end

   // hard stop if anything hangs
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, %0d errors so far", MAX_CYCLES, errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //------------------------------------------------------------------------
   // expected values and helpers
   //------------------------------------------------------------------------
   function automatic logic [DATA_W-1:0] model_word(input int unsigned adr,
                                                    input int unsigned serial);
      return DATA_W'(adr * 32'h1F3 + serial * 32'h10001);
   endfunction

   function automatic logic [DATA_W-1:0] bank_xor(input int unsigned serial);
      logic [DATA_W-1:0] acc;
      acc = '0;
      for (int unsigned a = 0; a < WORDS; a++) begin
         acc ^= model_word(a, serial);
      end
      return acc;
   endfunction

   task automatic expect_eq(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("FAIL %s %s expected %h actual %h", test, what, exp, act);
      end
   endtask

   // acked addresses run 0..WORDS-1 in order within one fetch
   always @(posedge clk) begin
      if (corr_cyc !== 1'b1) begin
         want_adr <= 0;
      end else if (corr_stb && corr_ack) begin
         expect_eq("corr_bus", "address", want_adr, 32'(corr_adr));
         want_adr <= want_adr + 1;
      end
   end

   task automatic pulse_switch();
      bank_switch <= 1'b1;
      @(posedge clk);
      bank_switch <= 1'b0;
      @(posedge clk);
   endtask

   task automatic release_buffer(input string test);
      host_done <= 1'b1;
      @(posedge clk);
      host_done <= 1'b0;
      @(posedge clk);
      expect_eq(test, "available after release", 32'd0, 32'(available));
   endtask

   // waits for the next bank and checks its checksum
   task automatic collect_bank(input string test);
      while (!available) @(posedge clk);
      expect_eq(test, "checksum", 32'(bank_xor(next_serial)), 32'(checksum));
      cur_serial  = next_serial;
      next_serial = next_serial + 1;
   endtask

   // one cycle strobe with ack and byte due exactly one cycle later
   task automatic read_byte(input string test, input int unsigned word, input int unsigned lane,
                            output logic [BYTE_W-1:0] byt);
      host_cyc <= 1'b1;
      host_stb <= 1'b1;
      host_adr <= {ABITS'(word), LANE_BITS'(lane)};
      @(posedge clk);
      host_cyc <= 1'b0;
      host_stb <= 1'b0;
      expect_eq(test, "ack in strobe cycle", 32'd0, 32'(host_ack));
      @(posedge clk);
      expect_eq(test, "ack one cycle later", 32'd1, 32'(host_ack));
      byt = host_byt;
   endtask

   task automatic readback_bank(input string test);
      logic [BYTE_W-1:0] byt;
      logic [DATA_W-1:0] wd;
      logic [BYTE_W-1:0] exp_b;
      for (int unsigned w = 0; w < WORDS; w++) begin
         wd = model_word(w, cur_serial);
         for (int unsigned l = 0; l < LANES; l++) begin
            read_byte(test, w, l, byt);
            exp_b = (l == 3) ? 8'h00 : wd[l*BYTE_W +: BYTE_W];   // top lane is padding
            expect_eq(test, $sformatf("word %0d lane %0d", w, l), 32'(exp_b), 32'(byt));
         end
      end
   endtask

   task automatic reset_status(input string test);
      expect_eq(test, "available", 32'd0, 32'(available));
      expect_eq(test, "overflow", 32'd0, 32'(overflow));
      expect_eq(test, "corr_cyc", 32'd0, 32'(corr_cyc));
      expect_eq(test, "corr_stb", 32'd0, 32'(corr_stb));
      expect_eq(test, "checksum", 32'd0, 32'(checksum));
   endtask

   //------------------------------------------------------------------------
   // directed tests
   //------------------------------------------------------------------------
   task automatic reset_values();
      reset_status("reset_values");
   endtask

   task automatic single_bank();
      pulse_switch();
      collect_bank("single_bank");
   endtask

   task automatic byte_readback();
      readback_bank("byte_readback");
   endtask

   task automatic bank_queueing();
      pulse_switch();                                 // both wait while the buffer is full
      pulse_switch();
      release_buffer("bank_queueing");
      collect_bank("bank_queueing");
      readback_bank("bank_queueing");
      expect_eq("bank_queueing", "overflow", 32'd0, 32'(overflow));
   endtask

   task automatic queue_overflow();
      pulse_switch();                                 // queue now at NBANK
      expect_eq("queue_overflow", "overflow before", 32'd0, 32'(overflow));
      pulse_switch();                                 // this one is dropped
      expect_eq("queue_overflow", "overflow", 32'd1, 32'(overflow));
      for (int i = 0; i < NBANK; i++) begin
         release_buffer("queue_overflow");
         collect_bank("queue_overflow");
      end
      release_buffer("queue_overflow");
      repeat (20) begin                               // nothing left to fetch
         @(posedge clk);
         expect_eq("queue_overflow", "corr_cyc idle", 32'd0, 32'(corr_cyc));
         expect_eq("queue_overflow", "available idle", 32'd0, 32'(available));
      end
   endtask

   task automatic reset_mid_fetch();
      pulse_switch();
      while (!corr_cyc) @(posedge clk);
      repeat (12) @(posedge clk);
      expect_eq("reset_mid_fetch", "fetch running", 32'd1, 32'(corr_cyc));
      next_serial = next_serial + 1;                  // aborted fetch still counts at the model
      rst <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      reset_status("reset_mid_fetch");
      pulse_switch();
      collect_bank("reset_mid_fetch");
      readback_bank("reset_mid_fetch");
   endtask

   //------------------------------------------------------------------------
   // main sequence
   //------------------------------------------------------------------------
   initial begin
      void'($urandom(SEED));
      rst         = 1'b1;
      host_cyc    = 1'b0;
      host_stb    = 1'b0;
      host_adr    = '0;
      bank_switch = 1'b0;
      host_done   = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      reset_values();
      single_bank();
      byte_readback();
      bank_queueing();
      queue_overflow();
      reset_mid_fetch();

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/vis_pkg.sv
hdl/vis_bank_queue.sv
hdl/vis_prefetch.sv
hdl/vis_readout_buf.sv
hdl/vis_top.sv
verif/vis_corr_model.sv
verif/vis_tb.sv
